// File: source/bus_ctrl_pkg.sv
// Board-control register block shared definitions
// Settings and readback address maps, word types and the per-port status layout

package bus_ctrl_pkg;

   // ------------------------------------------------------------------------
   // Widths with a meaning
   // ------------------------------------------------------------------------
   typedef logic [7:0]  set_addr_t;
   typedef logic [7:0]  rb_addr_t;
   typedef logic [31:0] reg_word_t;
   typedef logic [15:0] phy_status_t;

   localparam int MAX_SFP_PORTS = 8;

   // Wide enough to index every supported port
   typedef logic [$clog2(MAX_SFP_PORTS)-1:0] port_idx_t;

   // ------------------------------------------------------------------------
   // Address maps
   // ------------------------------------------------------------------------
   localparam set_addr_t SR_LEDS           = 8'd0;
   localparam set_addr_t SR_SW_RST         = 8'd1;
   localparam set_addr_t SR_CLOCK_CTRL     = 8'd2;
   localparam set_addr_t SR_SFPP_CTRL_BASE = 8'd8;

   localparam rb_addr_t RB_COUNTER          = 8'd0;
   localparam rb_addr_t RB_CLK_STATUS       = 8'd3;
   localparam rb_addr_t RB_COMPAT_NUM       = 8'd6;
   localparam rb_addr_t RB_SFPP_STATUS_BASE = 8'd8;

   localparam logic [15:0] COMPAT_MAJOR     = 16'h0014;
   localparam logic [15:0] COMPAT_MINOR     = 16'h0000;

   // Bit 6 enables the GPSDO out of reset
   localparam logic [7:0]  CLOCK_CTRL_RESET = 8'h40;

   // ------------------------------------------------------------------------
   // Bundles
   // ------------------------------------------------------------------------
   // mod_abs lands in the highest bit of every triplet
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      reg_word_t data;
   } set_bus_t;

   typedef struct packed {
      phy_status_t phy;
      sfp_pins_t   chgd;
      sfp_pins_t   sync;
   } port_status_t;

   typedef enum logic [2:0] {
      RB_SRC_COUNTER,
      RB_SRC_CLK_STATUS,
      RB_SRC_COMPAT,
      RB_SRC_PORT,
      RB_SRC_NONE
   } rb_src_e;

   typedef struct packed {
      rb_src_e   src;
      port_idx_t port;
   } rb_sel_t;

endpackage

// File: source/settings_decoder.sv
`timescale 1ns/1ps
// Settings bus decoder with the LED, soft-reset and clock-control registers
// Also turns readback addresses into a source select and per-port read clears

module settings_decoder #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  bus_ctrl_pkg::set_bus_t   i_set,
   input  bus_ctrl_pkg::rb_addr_t   i_rb_addr,
   input  logic                     i_rb_rd_stb,
   output logic [7:0]               o_leds,
   output logic [3:0]               o_sw_rst,
   output logic [7:0]               o_clock_control,
   output logic [NUM_SFP_PORTS-1:0] o_port_wr,
   output logic [1:0]               o_port_wr_data,
   output logic [NUM_SFP_PORTS-1:0] o_port_rd_clr,
   output bus_ctrl_pkg::rb_sel_t    o_rb_sel
);

   import bus_ctrl_pkg::*;

   rb_addr_t rb_port_off;

   // ------------------------------------------------------------------------
   // Board control registers
   // ------------------------------------------------------------------------
   // Soft reset bits
   //   [0] PHY
   //   [1] radio clock domain
   //   [2] radio clock PLL
   //   [3] ADC input delay control
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_leds          <= '0;
         o_sw_rst        <= '0;
         o_clock_control <= CLOCK_CTRL_RESET;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_LEDS:       o_leds          <= i_set.data[7:0];
            SR_SW_RST:     o_sw_rst        <= i_set.data[3:0];
            SR_CLOCK_CTRL: o_clock_control <= i_set.data[7:0];
            default: begin
            end
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Per-port strobes
   // ------------------------------------------------------------------------
   // Rate-select field is the low two data bits
   assign o_port_wr_data = i_set.data[1:0];

   always_comb begin
      for (int p = 0; p < NUM_SFP_PORTS; p++) begin
         o_port_wr[p]     = i_set.stb &&
                            (i_set.addr == SR_SFPP_CTRL_BASE + set_addr_t'(p));
         o_port_rd_clr[p] = i_rb_rd_stb &&
                            (i_rb_addr == RB_SFPP_STATUS_BASE + rb_addr_t'(p));
      end
   end

   // ------------------------------------------------------------------------
   // Readback source select
   // ------------------------------------------------------------------------
   assign rb_port_off = i_rb_addr - RB_SFPP_STATUS_BASE;

   always_comb begin
      o_rb_sel.port = '0;
      case (i_rb_addr)
         RB_COUNTER:    o_rb_sel.src = RB_SRC_COUNTER;
         RB_CLK_STATUS: o_rb_sel.src = RB_SRC_CLK_STATUS;
         RB_COMPAT_NUM: o_rb_sel.src = RB_SRC_COMPAT;
         default: begin
            // Status window covers only the ports that exist
            if ((i_rb_addr >= RB_SFPP_STATUS_BASE) &&
                (rb_port_off < rb_addr_t'(NUM_SFP_PORTS))) begin
               o_rb_sel.src  = RB_SRC_PORT;
               o_rb_sel.port = port_idx_t'(rb_port_off);
            end else begin
               o_rb_sel.src  = RB_SRC_NONE;
            end
         end
      endcase
   end

   // ------------------------------------------------------------------------
   // Checks
   // ------------------------------------------------------------------------
   // At most one port sees a write or a read clear per cycle
   a_port_wr_onehot: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      $onehot0(o_port_wr)
   );

   a_port_rd_clr_onehot: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      $onehot0(o_port_rd_clr)
   );

endmodule

// File: source/sfp_port_monitor.sv
`timescale 1ns/1ps
// Status and control of one SFP+ cage
// Pin and PHY status synchronizers, sticky change flags and rate-select register

module sfp_port_monitor (
   input  logic                       clk,
   input  logic                       i_arst_n,
   input  bus_ctrl_pkg::sfp_pins_t    i_pins,
   input  bus_ctrl_pkg::phy_status_t  i_phy_status,
   input  logic                       i_wr,
   input  logic [1:0]                 i_wr_data,
   input  logic                       i_rd_clr,
   output bus_ctrl_pkg::port_status_t o_status,
   output logic [1:0]                 o_rs_pull
);

   import bus_ctrl_pkg::*;

   sfp_pins_t   pins_meta;
   sfp_pins_t   pins_sync;
   sfp_pins_t   pins_prev;
   sfp_pins_t   pins_diff;
   sfp_pins_t   chgd;
   phy_status_t phy_meta;
   phy_status_t phy_sync;

   // ------------------------------------------------------------------------
   // Input synchronizers
   // ------------------------------------------------------------------------
   // Pins and PHY status are asynchronous, every bit on its own
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_meta <= '0;
         pins_sync <= '0;
         phy_meta  <= '0;
         phy_sync  <= '0;
      end else begin
         pins_meta <= i_pins;
         pins_sync <= pins_meta;
         phy_meta  <= i_phy_status;
         phy_sync  <= phy_meta;
      end
   end

   // ------------------------------------------------------------------------
   // Change detection
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pins_prev <= '0;
      end else begin
         pins_prev <= pins_sync;
      end
   end

   assign pins_diff = pins_sync ^ pins_prev;

   // Flags stay up until a status read, a fresh change beats the clear
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         chgd <= '0;
      end else if (i_rd_clr) begin
         chgd <= pins_diff;
      end else begin
         chgd <= chgd | pins_diff;
      end
   end

   assign o_status = '{phy: phy_sync, chgd: chgd, sync: pins_sync};

   // ------------------------------------------------------------------------
   // Rate select
   // ------------------------------------------------------------------------
   // A set bit pulls the open-drain RS pin low
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rs_pull <= 2'b00;
      end else if (i_wr) begin
         o_rs_pull <= i_wr_data;
      end
   end

   // No flag rises without a detected change one cycle before
   a_flag_needs_change: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      (chgd & $past(~chgd & ~pins_diff)) == 3'b000
   );

endmodule

// File: source/readback_mux.sv
`timescale 1ns/1ps
// Readback word selection for the board-control block
// Holds the free-running counter and formats the per-port status word

module readback_mux #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                                          clk,
   input  logic                                          i_arst_n,
   input  bus_ctrl_pkg::rb_sel_t                         i_rb_sel,
   input  bus_ctrl_pkg::port_status_t [NUM_SFP_PORTS-1:0] i_port_status,
   input  logic [7:0]                                    i_clock_status,
   output bus_ctrl_pkg::reg_word_t                       o_rb_data
);

   import bus_ctrl_pkg::*;

   reg_word_t    counter;
   port_status_t port_sel;

   // Free-running uptime counter
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   // Status of the addressed port
   always_comb begin
      port_sel = '0;
      for (int p = 0; p < NUM_SFP_PORTS; p++) begin
         if (i_rb_sel.port == port_idx_t'(p)) begin
            port_sel = i_port_status[p];
         end
      end
   end

   // ------------------------------------------------------------------------
   // Readback word
   // ------------------------------------------------------------------------
   // Port word: PHY status on top, then change flags over synced pins
   always_comb begin
      case (i_rb_sel.src)
         RB_SRC_COUNTER:    o_rb_data = counter;
         RB_SRC_CLK_STATUS: o_rb_data = {24'h000000, i_clock_status};
         RB_SRC_COMPAT:     o_rb_data = {COMPAT_MAJOR, COMPAT_MINOR};
         RB_SRC_PORT:       o_rb_data = {port_sel.phy, 10'b0, port_sel.chgd, port_sel.sync};
         default:           o_rb_data = '0;
      endcase
   end

   // The decoder only ever selects a port that is built
   a_port_in_range: assert property (
      @(posedge clk) disable iff (!i_arst_n)
      (i_rb_sel.src == RB_SRC_PORT) |-> (i_rb_sel.port < NUM_SFP_PORTS)
   );

endmodule

// File: source/sfp_bus_ctrl.sv
`timescale 1ns/1ps
// Board-control register block of the radio motherboard
// Settings decoder, one monitor per SFP+ port and the readback multiplexer

module sfp_bus_ctrl #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                                          clk,
   input  logic                                          i_arst_n,
   input  bus_ctrl_pkg::set_bus_t                        i_set,
   input  bus_ctrl_pkg::rb_addr_t                        i_rb_addr,
   input  logic                                          i_rb_rd_stb,
   input  bus_ctrl_pkg::sfp_pins_t [NUM_SFP_PORTS-1:0]   i_sfp_pins,
   input  bus_ctrl_pkg::phy_status_t [NUM_SFP_PORTS-1:0] i_phy_status,
   input  logic [7:0]                                    i_clock_status,
   output logic [7:0]                                    o_leds,
   output logic [3:0]                                    o_sw_rst,
   output logic [7:0]                                    o_clock_control,
   output logic [NUM_SFP_PORTS-1:0][1:0]                 o_sfp_rs_pull,
   output bus_ctrl_pkg::reg_word_t                       o_rb_data
);

   import bus_ctrl_pkg::*;

   logic [NUM_SFP_PORTS-1:0]         port_wr;
   logic [1:0]                       port_wr_data;
   logic [NUM_SFP_PORTS-1:0]         port_rd_clr;
   rb_sel_t                          rb_sel;
   port_status_t [NUM_SFP_PORTS-1:0] port_status;

   // Status window and port index only cover this many cages
   if (NUM_SFP_PORTS < 1 || NUM_SFP_PORTS > MAX_SFP_PORTS) begin : g_bad_port_count
      $error("NUM_SFP_PORTS must be between 1 and %0d", MAX_SFP_PORTS);
   end

   settings_decoder #(
      .NUM_SFP_PORTS (NUM_SFP_PORTS)
   ) u_decoder (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_set           (i_set),
      .i_rb_addr       (i_rb_addr),
      .i_rb_rd_stb     (i_rb_rd_stb),
      .o_leds          (o_leds),
      .o_sw_rst        (o_sw_rst),
      .o_clock_control (o_clock_control),
      .o_port_wr       (port_wr),
      .o_port_wr_data  (port_wr_data),
      .o_port_rd_clr   (port_rd_clr),
      .o_rb_sel        (rb_sel)
   );

   // ------------------------------------------------------------------------
   // SFP+ cages
   // ------------------------------------------------------------------------
   for (genvar p = 0; p < NUM_SFP_PORTS; p++) begin : g_port
      sfp_port_monitor u_monitor (
         .clk          (clk),
         .i_arst_n     (i_arst_n),
         .i_pins       (i_sfp_pins[p]),
         .i_phy_status (i_phy_status[p]),
         .i_wr         (port_wr[p]),
         .i_wr_data    (port_wr_data),
         .i_rd_clr     (port_rd_clr[p]),
         .o_status     (port_status[p]),
         .o_rs_pull    (o_sfp_rs_pull[p])
      );
   end

   readback_mux #(
      .NUM_SFP_PORTS (NUM_SFP_PORTS)
   ) u_readback (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_rb_sel       (rb_sel),
      .i_port_status  (port_status),
      .i_clock_status (i_clock_status),
      .o_rb_data      (o_rb_data)
   );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a set number of cycles

module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 16
) (
   output logic o_clk,
   output logic o_arst_n
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      o_arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_arst_n = 1'b1;
   end

endmodule

// File: test/tb_sfp_bus_ctrl.sv
`timescale 1ns/1ps
// Testbench for the board-control register block
// Cycle model of registers, counter and SFP+ flags, compared on every falling edge

module tb_sfp_bus_ctrl;

   import bus_ctrl_pkg::*;

   localparam int NP            = 2;
   localparam int PERIOD_NS     = 4;
   localparam int RESET_CYCLES  = 16;
   localparam int WRITE_CYCLES  = 200;
   localparam int PIN_CYCLES    = 300;
   localparam int TOTAL_CYCLES  = WRITE_CYCLES + PIN_CYCLES + 100;
   localparam int WATCHDOG_NS   = (2 * TOTAL_CYCLES + RESET_CYCLES) * PERIOD_NS;

   logic                   clk;
   logic                   arst_n;
   set_bus_t               set_bus;
   rb_addr_t               rb_addr;
   logic                   rb_rd_stb;
   sfp_pins_t [NP-1:0]     sfp_pins;
   phy_status_t [NP-1:0]   phy_status;
   logic [7:0]             clock_status;
   logic [7:0]             leds;
   logic [3:0]             sw_rst;
   logic [7:0]             clock_control;
   logic [NP-1:0][1:0]     rs_pull;
   reg_word_t              rb_data;

   // Model state
   logic [7:0]  m_leds;
   logic [3:0]  m_sw_rst;
   logic [7:0]  m_clk_ctrl;
   logic [1:0]  m_rs [NP];
   reg_word_t   m_counter;
   sfp_pins_t   m_meta [NP];
   sfp_pins_t   m_sync [NP];
   sfp_pins_t   m_prev [NP];
   sfp_pins_t   m_chgd [NP];
   phy_status_t m_phy_meta [NP];
   phy_status_t m_phy_sync [NP];

   integer      seed;
   logic        check_en;

   tb_clock_gen #(
      .PERIOD_NS    (PERIOD_NS),
      .RESET_CYCLES (RESET_CYCLES)
   ) u_clock_gen (
      .o_clk    (clk),
      .o_arst_n (arst_n)
   );

   sfp_bus_ctrl #(
      .NUM_SFP_PORTS (NP)
   ) DUT (
      .clk             (clk),
      .i_arst_n        (arst_n),
      .i_set           (set_bus),
      .i_rb_addr       (rb_addr),
      .i_rb_rd_stb     (rb_rd_stb),
      .i_sfp_pins      (sfp_pins),
      .i_phy_status    (phy_status),
      .i_clock_status  (clock_status),
      .o_leds          (leds),
      .o_sw_rst        (sw_rst),
      .o_clock_control (clock_control),
      .o_sfp_rs_pull   (rs_pull),
      .o_rb_data       (rb_data)
   );

   // ------------------------------------------------------------------------
   // Reference model, one step per rising edge
   // ------------------------------------------------------------------------
   always @(posedge clk) begin : step_model
      logic       clr;
      logic [2:0] kept;
      if (!arst_n) begin
         m_leds     = 8'h00;
         m_sw_rst   = 4'h0;
         m_clk_ctrl = 8'h40;
         m_counter  = 32'd0;
         for (int p = 0; p < NP; p++) begin
            m_rs[p]       = 2'b00;
            m_meta[p]     = 3'b000;
            m_sync[p]     = 3'b000;
            m_prev[p]     = 3'b000;
            m_chgd[p]     = 3'b000;
            m_phy_meta[p] = 16'h0000;
            m_phy_sync[p] = 16'h0000;
         end
      end else begin
         m_counter = m_counter + 32'd1;
         for (int p = 0; p < NP; p++) begin
            clr  = rb_rd_stb && (rb_addr == RB_SFPP_STATUS_BASE + rb_addr_t'(p));
            kept = clr ? 3'b000 : m_chgd[p];
            // Set wins over clear
            m_chgd[p]     = kept | (m_sync[p] ^ m_prev[p]);
            m_prev[p]     = m_sync[p];
            m_sync[p]     = m_meta[p];
            m_meta[p]     = sfp_pins[p];
            m_phy_sync[p] = m_phy_meta[p];
            m_phy_meta[p] = phy_status[p];
            if (set_bus.stb && (set_bus.addr == SR_SFPP_CTRL_BASE + set_addr_t'(p))) begin
               m_rs[p] = set_bus.data[1:0];
            end
         end
         if (set_bus.stb) begin
            case (set_bus.addr)
               SR_LEDS:       m_leds     = set_bus.data[7:0];
               SR_SW_RST:     m_sw_rst   = set_bus.data[3:0];
               SR_CLOCK_CTRL: m_clk_ctrl = set_bus.data[7:0];
               default: begin
               end
            endcase
         end
      end
   end

   function automatic port_status_t model_status(input int p);
      return {m_phy_sync[p], m_chgd[p], m_sync[p]};
   endfunction

   function automatic reg_word_t model_readback(input rb_addr_t addr);
      reg_word_t word;
      word = 32'h0000_0000;
      if (addr == RB_COUNTER) begin
         word = m_counter;
      end else if (addr == RB_CLK_STATUS) begin
         word = {24'h000000, clock_status};
      end else if (addr == RB_COMPAT_NUM) begin
         word = 32'h0014_0000;
      end else begin
         for (int p = 0; p < NP; p++) begin
            if (addr == RB_SFPP_STATUS_BASE + rb_addr_t'(p)) begin
               word = {m_phy_sync[p], 10'b0, m_chgd[p], m_sync[p]};
            end
         end
      end
      return word;
   endfunction

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic stop_run();
      $display("TEST FAIL");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   task automatic check_word(input reg_word_t got, input reg_word_t exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_status(input port_status_t got, input port_status_t exp,
                               input string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s got phy %h chgd %b sync %b expected phy %h chgd %b sync %b",
                  $time, what, got.phy, got.chgd, got.sync, exp.phy, exp.chgd, exp.sync);
         stop_run();
      end
   endtask

   task automatic check_ctrl(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("FAILED at %0d ns: %s got %h expected %h", $time, what, got, exp);
         stop_run();
      end
   endtask

   // Port word against the driven inputs once they have settled
   task automatic expect_port(input int p, input sfp_pins_t flags, input string what);
      port_status_t got_st;
      port_status_t exp_st;
      #1;
      got_st = {rb_data[31:16], rb_data[5:0]};
      exp_st = {phy_status[p], flags, sfp_pins[p]};
      check_status(got_st, exp_st, what);
   endtask

   // Every cycle, once inputs have been driven
   always begin : compare_outputs
      port_status_t got_st;
      @(negedge clk);
      #1;
      if (check_en) begin
         check_ctrl(leds, m_leds, "LED register");
         check_ctrl({4'h0, sw_rst}, {4'h0, m_sw_rst}, "soft reset register");
         check_ctrl(clock_control, m_clk_ctrl, "clock control register");
         for (int p = 0; p < NP; p++) begin
            check_ctrl({6'b0, rs_pull[p]}, {6'b0, m_rs[p]}, "rate select pull");
         end
         check_word(rb_data, model_readback(rb_addr), "readback word");
         if ((rb_addr >= RB_SFPP_STATUS_BASE) &&
             (rb_addr < RB_SFPP_STATUS_BASE + rb_addr_t'(NP))) begin
            got_st = {rb_data[31:16], rb_data[5:0]};
            check_status(got_st, model_status(int'(rb_addr - RB_SFPP_STATUS_BASE)),
                         "port status");
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired before the stimulus finished");
      $display("TEST FAIL");
      $fatal(1, "Simulation timed out");
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial begin : run_tests
      logic [31:0] tmp;
      logic [31:0] tmp2;
      reg_word_t   first_count;
      reg_word_t   second_count;
      int          gap;
      seed         = 32'ha4ba;
      set_bus      = '0;
      rb_addr      = RB_COUNTER;
      rb_rd_stb    = 1'b0;
      sfp_pins     = '0;
      phy_status   = '0;
      clock_status = 8'h00;
      check_en     = 1'b0;
      @(posedge arst_n);

      // Reset values
      @(negedge clk);
      check_en = 1'b1;
      rb_addr  = RB_COMPAT_NUM;
      #1;
      check_ctrl(leds, 8'h00, "LEDs after reset");
      check_ctrl({4'h0, sw_rst}, 8'h00, "soft reset after reset");
      check_ctrl(clock_control, 8'h40, "clock control after reset");
      check_ctrl({4'h0, rs_pull}, 8'h00, "rate select after reset");
      check_word(rb_data, 32'h0014_0000, "compat number");
      for (int p = 0; p < NP; p++) begin
         @(negedge clk);
         rb_addr = RB_SFPP_STATUS_BASE + rb_addr_t'(p);
         expect_port(p, 3'b000, "flags after reset");
      end

      // Random settings writes, unmapped addresses included
      for (int i = 0; i < WRITE_CYCLES; i++) begin
         @(negedge clk);
         tmp          = $random(seed);
         set_bus.stb  = tmp[0];
         set_bus.addr = (tmp[1] && tmp[2]) ? tmp[23:16] : {4'h0, tmp[7:4]};
         set_bus.data = $random(seed);
         rb_addr      = {4'h0, tmp[11:8]};
         clock_status = tmp[31:24];
      end

      // Counter distance
      @(negedge clk);
      set_bus.stb = 1'b0;
      rb_addr     = RB_COUNTER;
      tmp         = $random(seed);
      gap         = 5 + int'(tmp[4:0]);
      #1;
      first_count = rb_data;
      repeat (gap) @(negedge clk);
      #1;
      second_count = rb_data;
      check_word(second_count - first_count, reg_word_t'(gap), "counter distance");

      // Pin and PHY toggles with status reads
      for (int i = 0; i < PIN_CYCLES; i++) begin
         @(negedge clk);
         tmp  = $random(seed);
         tmp2 = $random(seed);
         if (tmp[2:0] == 3'b000) begin
            sfp_pins[tmp[3]] = sfp_pins[tmp[3]] ^ tmp[6:4];
         end
         if (tmp[9:7] == 3'b000) begin
            phy_status[tmp[10]] = tmp2[15:0];
         end
         rb_addr   = (tmp[14:12] == 3'b000) ? {4'h0, tmp[19:16]} :
                     RB_SFPP_STATUS_BASE + rb_addr_t'(tmp[11]);
         rb_rd_stb = tmp[20] & tmp[21];
      end

      // Clear on read, pins held steady first
      @(negedge clk);
      rb_rd_stb = 1'b0;
      repeat (4) @(negedge clk);
      for (int p = 0; p < NP; p++) begin
         @(negedge clk);
         rb_addr   = RB_SFPP_STATUS_BASE + rb_addr_t'(p);
         rb_rd_stb = 1'b1;
         @(negedge clk);
         rb_rd_stb = 1'b0;
         expect_port(p, 3'b000, "flags after first clear");
         @(negedge clk);
         sfp_pins[p] = sfp_pins[p] ^ 3'b101;
         repeat (4) @(negedge clk);
         expect_port(p, 3'b101, "flags after pin change");
         @(negedge clk);
         expect_port(p, 3'b101, "flags after plain read");
         @(negedge clk);
         rb_rd_stb = 1'b1;
         expect_port(p, 3'b101, "flags on clearing read");
         @(negedge clk);
         rb_rd_stb = 1'b0;
         expect_port(p, 3'b000, "flags after clearing read");
      end

      // Clock status and unmapped addresses
      @(negedge clk);
      clock_status = 8'h5a;
      rb_addr      = RB_CLK_STATUS;
      #1;
      check_word(rb_data, 32'h0000_005a, "clock status");
      @(negedge clk);
      rb_addr = 8'h05;
      #1;
      check_word(rb_data, 32'h0000_0000, "unmapped address 0x05");
      @(negedge clk);
      rb_addr = RB_SFPP_STATUS_BASE + rb_addr_t'(NP);
      #1;
      check_word(rb_data, 32'h0000_0000, "status of a port that is not built");
      @(negedge clk);
      rb_addr = 8'hff;
      #1;
      check_word(rb_data, 32'h0000_0000, "unmapped address 0xff");

      @(negedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

// File: all.f
source/bus_ctrl_pkg.sv
source/settings_decoder.sv
source/sfp_port_monitor.sv
source/readback_mux.sv
source/sfp_bus_ctrl.sv
test/tb_clock_gen.sv
test/tb_sfp_bus_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board-control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sfp_bus_ctrl \
   -f all.f -Mdir obj_dir -o sim_tb_sfp_bus_ctrl
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/sim_tb_sfp_bus_ctrl 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
